/* hdl/kick_pkg.sv */
// Kick-off port constants
// Bus widths and address map of the descriptor kick-off window
// that software writes through the command/response port
package kick_pkg;

    // ==============================
    // Bus widths
    // ==============================

    localparam int kick_addr_width = 32;
    localparam int kick_data_width = 32;

    // ==============================
    // Address map
    // ==============================

    // One word per channel, packed from the window base
    localparam int kick_num_channels = 8;
    localparam int kick_window_bytes = 32;

    // Channel number sits in the word index bits
    localparam int kick_chan_lsb = 2;
    localparam int kick_chan_msb = 4;

    // Only the low address bits take part in the range check
    localparam int kick_decode_bits = 12;

endpackage : kick_pkg

/* hdl/desc_pkg.sv */
// Descriptor types
// Channel number, descriptor address and fetch timing shared by
// the channel bank, the fetch timer and the kick-off handshake
package desc_pkg;

    // ==============================
    // Descriptor fields
    // ==============================

    // Eight channels
    typedef logic [2:0] chan_id_t;

    // Full 64-bit descriptor pointer, upper half zero from a 32-bit write
    typedef logic [63:0] desc_addr_t;

    // ==============================
    // Fetch timing
    // ==============================

    // Count wide enough for the longest modeled fetch
    typedef logic [2:0] fetch_count_t;

    // Cycles from fetch start to fetch done
    localparam fetch_count_t fetch_cycles = 3'd4;

endpackage : desc_pkg

/* hdl/desc_kick_if.sv */
// Descriptor kick-off handshake
// Carries one descriptor address and its channel from the router
// into the channel bank with a valid/ready transfer
`timescale 1ns/1ps

interface desc_kick_if;

    import desc_pkg::*;

    // Level from the router, held until ready is seen
    logic       kick_valid;
    chan_id_t   kick_chan;
    desc_addr_t kick_addr;

    // Slot for kick_chan is empty
    logic       kick_ready;

    // Router side drives the request
    modport router (
        output kick_valid,
        output kick_chan,
        output kick_addr,
        input  kick_ready
    );

    // Bank side answers with slot state
    modport bank (
        input  kick_valid,
        input  kick_chan,
        input  kick_addr,
        output kick_ready
    );

endinterface : desc_kick_if

/* hdl/kick_router.sv */
// Kick-off router
// Decodes a write on the command port into a channel number,
// checks the address window and forwards the write data as a
// descriptor address. Waits on the channel bank before answering.
// Reads and out-of-range writes get an error response.
`timescale 1ns/1ps

module kick_router (
    input  logic                                clk,
    input  logic                                reset,

    // Command side
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  logic [kick_pkg::kick_addr_width-1:0] cmd_addr,
    input  logic [kick_pkg::kick_data_width-1:0] cmd_wdata,
    input  logic                                cmd_write,

    // Response side
    output logic                                rsp_valid,
    input  logic                                rsp_ready,
    output logic                                rsp_error,

    // High while a good kick-off is in progress
    output logic                                kickoff_hit,

    desc_kick_if.router                         kick
);

    import kick_pkg::*;
    import desc_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_route,
        st_respond
    } state_t;

    state_t state;
    state_t state_next;

    // Captured command
    chan_id_t                    r_chan;
    logic [kick_data_width-1:0]  r_wdata;
    logic                        r_error;

    logic                        addr_in_range;

    // ==============================
    // Address decode
    // ==============================

    // Upper address bits are don't care
    assign addr_in_range = cmd_addr[kick_decode_bits-1:0] < kick_window_bytes;

    // ==============================
    // State machine
    // ==============================

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                // Every command goes through route, errors included
                if (cmd_valid) begin
                    state_next = st_route;
                end
            end
            st_route: begin
                // Busy channel keeps us here
                if (r_error || kick.kick_ready) begin
                    state_next = st_respond;
                end
            end
            st_respond: begin
                if (rsp_ready) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= st_idle;
            r_error <= 1'b0;
        end else begin
            state <= state_next;
            // Read or outside the window is an error
            if (state == st_idle && cmd_valid) begin
                r_error <= !cmd_write || !addr_in_range;
            end
        end
    end

    // Payload capture at the accepting edge
    always_ff @(posedge clk) begin
        if (state == st_idle && cmd_valid) begin
            r_chan  <= cmd_addr[kick_chan_msb:kick_chan_lsb];
            r_wdata <= cmd_wdata;
        end
    end

    // ==============================
    // Outputs
    // ==============================

    assign cmd_ready = (state == st_idle);
    assign rsp_valid = (state == st_respond);
    assign rsp_error = r_error;

    assign kickoff_hit = (state == st_route || state == st_respond) && !r_error;

    // Errors never reach the bank
    assign kick.kick_valid = (state == st_route) && !r_error;
    assign kick.kick_chan  = r_chan;
    // Zero-extend to the full descriptor pointer
    assign kick.kick_addr  = desc_addr_t'(r_wdata);

endmodule : kick_router

/* hdl/desc_channel_bank.sv */
// Descriptor channel bank
// One pending descriptor address per channel. A channel with a
// pending address refuses new kicks. Pending channels are handed
// to the shared fetch timer in round-robin order.
`timescale 1ns/1ps

module desc_channel_bank (
    input  logic                 clk,
    input  logic                 reset,

    desc_kick_if.bank            kick,

    // Fetch timer
    output logic                 fetch_start,
    input  logic                 fetch_busy,
    input  logic                 fetch_done,

    // In-flight slot, valid with fetch_done
    output desc_pkg::chan_id_t   done_chan,
    output desc_pkg::desc_addr_t done_addr
);

    import kick_pkg::*;
    import desc_pkg::*;

    // Slot storage
    desc_addr_t                   slot_addr [kick_num_channels];
    logic [kick_num_channels-1:0] pending;
    logic [kick_num_channels-1:0] issued;

    // Arbitration
    logic [kick_num_channels-1:0] candidates;
    chan_id_t                     rr_ptr;
    chan_id_t                     cand;
    chan_id_t                     pick_chan;
    logic                         pick_found;
    chan_id_t                     inflight;

    logic                         kick_fire;

    // ==============================
    // Kick-off side
    // ==============================

    assign kick.kick_ready = !pending[kick.kick_chan];
    assign kick_fire       = kick.kick_valid && kick.kick_ready;

    always_ff @(posedge clk) begin
        if (kick_fire) begin
            slot_addr[kick.kick_chan] <= kick.kick_addr;
        end
    end

    // ==============================
    // Round-robin issue
    // ==============================

    // Waiting for the timer, not yet started
    assign candidates = pending & ~issued;

    // First candidate at or after the pointer, wrapping
    always_comb begin
        pick_found = 1'b0;
        pick_chan  = rr_ptr;
        cand       = rr_ptr;
        for (int i = 0; i < kick_num_channels; i++) begin
            cand = chan_id_t'(rr_ptr + i);
            if (!pick_found && candidates[cand]) begin
                pick_found = 1'b1;
                pick_chan  = cand;
            end
        end
    end

    assign fetch_start = pick_found && !fetch_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending  <= '0;
            issued   <= '0;
            rr_ptr   <= '0;
            inflight <= '0;
        end else begin
            // Free the finished slot, its channel accepts again next cycle
            if (fetch_done) begin
                pending[inflight] <= 1'b0;
                issued[inflight]  <= 1'b0;
            end
            if (kick_fire) begin
                pending[kick.kick_chan] <= 1'b1;
            end
            // New start may share the done cycle; inflight updates after the free
            if (fetch_start) begin
                issued[pick_chan] <= 1'b1;
                inflight          <= pick_chan;
                rr_ptr            <= pick_chan + chan_id_t'(1);
            end
        end
    end

    assign done_chan = inflight;
    assign done_addr = slot_addr[inflight];

endmodule : desc_channel_bank

/* hdl/fetch_timer.sv */
// Descriptor fetch timer
// Stands in for the memory fetch. Loaded on start, counts down
// and pulses done a fixed number of cycles after the start edge.
`timescale 1ns/1ps

module fetch_timer (
    input  logic clk,
    input  logic reset,
    input  logic fetch_start,
    output logic fetch_busy,
    output logic fetch_done
);

    import desc_pkg::*;

    fetch_count_t count;
    logic         done_q;

    // ==============================
    // Counter
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            count  <= '0;
            done_q <= 1'b0;
        end else begin
            // Last step registers into done, one edge after count==1
            done_q <= (count == fetch_count_t'(1));
            if (fetch_start) begin
                count <= fetch_cycles;
            end else if (count != '0) begin
                count <= count - fetch_count_t'(1);
            end
        end
    end

    // Idle again in the done cycle, so the next fetch can start there
    assign fetch_busy = (count != '0);
    assign fetch_done = done_q;

endmodule : fetch_timer

/* hdl/stream_kick_top.sv */
// Streaming DMA kick-off subsystem
// Command port in, descriptor fetch completions out.
// Router decodes writes, channel bank holds pending addresses,
// fetch timer models the descriptor fetch latency.
`timescale 1ns/1ps

module stream_kick_top (
    input  logic                                clk,
    input  logic                                reset,

    // Command/response port
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  logic [kick_pkg::kick_addr_width-1:0] cmd_addr,
    input  logic [kick_pkg::kick_data_width-1:0] cmd_wdata,
    input  logic                                cmd_write,
    output logic                                rsp_valid,
    input  logic                                rsp_ready,
    output logic                                rsp_error,
    output logic                                kickoff_hit,

    // Fetch completion, one-cycle pulse, no back-pressure
    output logic                                done_valid,
    output desc_pkg::chan_id_t                  done_chan,
    output desc_pkg::desc_addr_t                done_addr
);

    // Router to bank
    desc_kick_if kick_bus ();

    // Bank to timer
    logic fetch_start;
    logic fetch_busy;
    logic fetch_done;

    kick_router i_router (
        .clk         (clk),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .cmd_write   (cmd_write),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_error   (rsp_error),
        .kickoff_hit (kickoff_hit),
        .kick        (kick_bus.router)
    );

    desc_channel_bank i_bank (
        .clk         (clk),
        .reset       (reset),
        .kick        (kick_bus.bank),
        .fetch_start (fetch_start),
        .fetch_busy  (fetch_busy),
        .fetch_done  (fetch_done),
        .done_chan   (done_chan),
        .done_addr   (done_addr)
    );

    fetch_timer i_timer (
        .clk         (clk),
        .reset       (reset),
        .fetch_start (fetch_start),
        .fetch_busy  (fetch_busy),
        .fetch_done  (fetch_done)
    );

    // Bank holds the in-flight slot through the done cycle
    assign done_valid = fetch_done;

endmodule : stream_kick_top

/* test/tb_stream_kick.sv */
// Testbench for the streaming DMA kick-off subsystem
// Drives writes and reads on the command port, keeps per-channel
// queues of expected descriptor addresses and checks completions,
// response errors, back-pressure and handshake rules with assertions
`timescale 1ns/1ps

module tb_stream_kick;

    import kick_pkg::*;
    import desc_pkg::*;

    localparam int num_trans   = 48;
    localparam int cycle_limit = 40 * num_trans + 200;
    // Every channel may still be waiting on the shared timer at the end
    localparam int drain_limit = kick_num_channels * 4 * fetch_cycles;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       cmd_valid;
    logic                       cmd_ready;
    logic [kick_addr_width-1:0] cmd_addr;
    logic [kick_data_width-1:0] cmd_wdata;
    logic                       cmd_write;
    logic                       rsp_valid;
    logic                       rsp_ready;
    logic                       rsp_error;
    logic                       kickoff_hit;
    logic                       done_valid;
    chan_id_t                   done_chan;
    desc_addr_t                 done_addr;

    // Expected addresses per channel, in completion order
    desc_addr_t                 exp_q [kick_num_channels][$];
    desc_addr_t                 exp_addr;
    logic [kick_addr_width-1:0] cur_addr;
    logic [kick_data_width-1:0] cur_data;
    logic                       cur_err;
    logic [31:0]                rng_state = 32'd83;
    int                         assert_errors = 0;
    int                         sb_errors = 0;
    int                         cycles = 0;

    stream_kick_top i_dut (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int outstanding();
        int total;
        total = 0;
        for (int c = 0; c < kick_num_channels; c++) begin
            total += exp_q[c].size();
        end
        return total;
    endfunction

    // ==============================
    // Stimulus
    // ==============================

    // One command, then the response; rsp_ready held low for hold cycles
    task automatic send_cmd(input logic [31:0] addr, input logic [31:0] data,
                            input logic write, input int hold);
        cmd_valid = 1'b1;
        cmd_addr  = addr;
        cmd_wdata = data;
        cmd_write = write;
        rsp_ready = (hold == 0);
        while (!cmd_ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
        while (!rsp_valid) begin
            @(posedge clk);
            #2;
        end
        repeat (hold) begin
            @(posedge clk);
            #2;
        end
        rsp_ready = 1'b1;
        @(posedge clk);
        #2;
    endtask

    // ==============================
    // Scoreboard
    // ==============================

    always @(posedge clk) begin
        if (!reset) begin
            // Completion pops the oldest write of its channel
            if (done_valid) begin
                if (exp_q[done_chan].size() == 0) begin
                    sb_errors++;
                    $display("Completion on channel %0d with no write outstanding", done_chan);
                end else begin
                    exp_addr = exp_q[done_chan].pop_front();
                    assert (done_addr == exp_addr) else begin
                        sb_errors++;
                        $display("[FAIL] completion_addr ch%0d expected %h actual %h",
                                 done_chan, exp_addr, done_addr);
                    end
                end
            end
            if (cmd_valid && cmd_ready) begin
                cur_addr <= cmd_addr;
                cur_data <= cmd_wdata;
                cur_err  <= !cmd_write || (cmd_addr[11:0] >= kick_window_bytes);
            end
            if (rsp_valid && rsp_ready) begin
                assert (rsp_error == cur_err) else begin
                    sb_errors++;
                    $display("[FAIL] rsp_error addr %h expected %0b actual %0b",
                             cur_addr, cur_err, rsp_error);
                end
                if (!cur_err) begin
                    // Bank holds one address, so a clean response means an empty channel
                    assert (exp_q[cur_addr[kick_chan_msb:kick_chan_lsb]].size() == 0) else begin
                        sb_errors++;
                        $display("[FAIL] back_pressure ch%0d expected 0 actual %0d",
                                 cur_addr[kick_chan_msb:kick_chan_lsb],
                                 exp_q[cur_addr[kick_chan_msb:kick_chan_lsb]].size());
                    end
                    exp_q[cur_addr[kick_chan_msb:kick_chan_lsb]].push_back(desc_addr_t'(cur_data));
                end
            end
        end
    end

    // ==============================
    // Handshake assertions
    // ==============================

    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done_valid |=> !done_valid) else begin
        assert_errors++;
        $display("[FAIL] done_pulse expected 0 actual %0b", $sampled(done_valid));
    end

    a_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid) else begin
        assert_errors++;
        $display("[FAIL] rsp_hold expected 1 actual %0b", $sampled(rsp_valid));
    end

    a_cmd_blocked: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> !cmd_ready) else begin
        assert_errors++;
        $display("[FAIL] cmd_blocked expected 0 actual %0b", $sampled(cmd_ready));
    end

    a_hit_good: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !cur_err |-> kickoff_hit) else begin
        assert_errors++;
        $display("[FAIL] hit_good expected 1 actual %0b", $sampled(kickoff_hit));
    end

    a_hit_error: assert property (@(posedge clk) disable iff (reset)
        kickoff_hit |-> !cur_err) else begin
        assert_errors++;
        $display("[FAIL] hit_error expected 0 actual %0b", $sampled(kickoff_hit));
    end

    // Watchdog
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            $display("assertion errors: %0d, scoreboard errors: %0d", assert_errors, sb_errors);
            $display("Errors found");
            $finish;
        end
    end

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        logic [2:0] ch;
        int         drain_cycles;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        cmd_write = 1'b0;
        rsp_ready = 1'b1;
        cur_addr  = '0;
        cur_data  = '0;
        cur_err   = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (cmd_ready) else begin
            sb_errors++;
            $display("cmd_ready is low after reset");
        end
        // In-range write, then a read
        send_cmd(32'h0000_0004, 32'hdead_0001, 1'b1, 0);
        send_cmd(32'h0000_0008, 32'h1234_5678, 1'b0, 0);
        // Out of window, then upper bits ignored
        send_cmd(32'h0000_0020, 32'h0bad_0020, 1'b1, 0);
        send_cmd(32'h0000_0ffc, 32'h0bad_0ffc, 1'b1, 0);
        send_cmd(32'h0000_100c, 32'hcafe_100c, 1'b1, 0);
        // Same channel twice, second one waits on the first fetch
        send_cmd(32'h0000_0014, 32'h5555_0001, 1'b1, 0);
        send_cmd(32'h0000_0014, 32'h5555_0002, 1'b1, 0);
        // Response held off
        send_cmd(32'h0000_0018, 32'h7777_0018, 1'b1, 5);
        // Random writes over all channels
        repeat (40) begin
            rng_state = xorshift(rng_state);
            ch        = rng_state[2:0];
            rng_state = xorshift(rng_state);
            send_cmd({rng_state[31:28], 23'd0, ch, 2'b00}, rng_state, 1'b1, 0);
        end
        // Remaining fetches finish one after another on the shared timer
        drain_cycles = 0;
        while (outstanding() != 0 && drain_cycles < drain_limit) begin
            @(posedge clk);
            drain_cycles++;
        end
        // Stray completions would show up here
        repeat (20) @(posedge clk);
        assert (outstanding() == 0) else begin
            sb_errors++;
            $display("Expected queues still hold entries after drain");
        end
        $display("assertion errors: %0d, scoreboard errors: %0d", assert_errors, sb_errors);
        if (assert_errors + sb_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : tb_stream_kick

/* sources.f */
hdl/kick_pkg.sv
hdl/desc_pkg.sv
hdl/desc_kick_if.sv
hdl/kick_router.sv
hdl/desc_channel_bank.sv
hdl/fetch_timer.sv
hdl/stream_kick_top.sv
test/tb_stream_kick.sv

/* Bender.yml */
package:
  name: stream_kick

sources:
  - hdl/kick_pkg.sv
  - hdl/desc_pkg.sv
  - hdl/desc_kick_if.sv
  - hdl/kick_router.sv
  - hdl/desc_channel_bank.sv
  - hdl/fetch_timer.sv
  - hdl/stream_kick_top.sv
  - target: test
    files:
      - test/tb_stream_kick.sv
